// File: Makefile
SIM  := obj_dir/Vtb_cps_daq_top
SRCS := $(wildcard verilog/*.sv test/*.sv)

.PHONY: all run clean

all: run

$(SIM): cps_daq_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_cps_daq_top -f cps_daq_top.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cps_daq_top.f
verilog/cps_pkg.sv
verilog/cmd_regs.sv
verilog/run_control.sv
verilog/frame_packer.sv
verilog/word_fifo.sv
verilog/cps_daq_top.sv
test/cps_checker.sv
test/tb_cps_daq_top.sv

// File: test/cps_checker.sv
module cps_checker import cps_pkg::*; (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  reg_rd,
  input logic [REG_DATA_W-1:0] reg_rdata,
  input logic                  rd_en,
  input logic [WORD_W-1:0]     rd_data,
  input logic                  fifo_empty
);

  logic [REG_DATA_W-1:0] reg_q [$];   // Expected register read values
  logic [WORD_W-1:0]     word_q [$];  // Expected FIFO words in order
  logic                  reg_pending;
  logic                  word_pending;
  int                    check_cnt   = 0;
  int                    error_cnt   = 0;
  int                    test_checks = 0;
  int                    test_errors = 0;

  task automatic queue_reg(input logic [REG_DATA_W-1:0] value);
    reg_q.push_back(value);
  endtask

  task automatic queue_word(input logic [WORD_W-1:0] value);
    word_q.push_back(value);
  endtask

  // Soft reset empties the FIFO
  task automatic drop_words();
    word_q.delete();
  endtask

  // Level of fifo_empty at a mid-cycle point
  task automatic check_empty(input logic expected);
    check_cnt++;
    if (fifo_empty !== expected) begin
      error_cnt++;
      $display("MISMATCH fifo_empty: expected 0x%0h, got 0x%0h", expected, fifo_empty);
    end
  endtask

  task automatic check_reg_read();
    logic [REG_DATA_W-1:0] expected;
    check_cnt++;
    if (reg_q.size() == 0) begin
      error_cnt++;
      $display("Register read returned data but no read was expected");
    end else begin
      expected = reg_q.pop_front();
      if (reg_rdata !== expected) begin
        error_cnt++;
        $display("MISMATCH reg_rdata: expected 0x%02h, got 0x%02h", expected, reg_rdata);
      end
    end
  endtask

  task automatic check_word_read();
    logic [WORD_W-1:0] expected;
    check_cnt++;
    if (word_q.size() == 0) begin
      error_cnt++;
      $display("FIFO returned word 0x%08h that should not have been written", rd_data);
    end else begin
      expected = word_q.pop_front();
      if (rd_data !== expected) begin
        error_cnt++;
        $display("MISMATCH rd_data: expected 0x%08h, got 0x%08h", expected, rd_data);
      end
    end
  endtask

  // Read data shows up one cycle after the strobe
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_pending  <= 1'b0;
      word_pending <= 1'b0;
    end else begin
      reg_pending  <= reg_rd;
      word_pending <= rd_en && !fifo_empty;
      if (reg_pending) begin
        check_reg_read();
      end
      if (word_pending) begin
        check_word_read();
      end
    end
  end

  task automatic end_test(input int num, input string name);
    if (word_q.size() != 0) begin
      error_cnt++;
      $display("FIFO ran empty with %0d expected words never read out", word_q.size());
      word_q.delete();
    end
    $display("Test %0d %s: %0d checks, %0d errors", num, name,
             check_cnt - test_checks, error_cnt - test_errors);
    test_checks = check_cnt;
    test_errors = error_cnt;
  endtask

  task automatic print_summary();
    $display("All tests done: %0d checks, %0d errors", check_cnt, error_cnt);
  endtask

endmodule

// File: test/tb_cps_daq_top.sv
module tb_cps_daq_top import cps_pkg::*; ();

  localparam int NUM_ROWS      = 8;
  localparam int FIFO_DEPTH    = 16;
  localparam int STROBE_GAP    = 20;
  localparam int TOTAL_STROBES = 50;  // Rows sent over all tests
  localparam int CYCLE_LIMIT   = 2 * TOTAL_STROBES * STROBE_GAP + 2000;

  logic                       clk;
  logic                       arst_n;
  logic                       reg_wr;
  logic                       reg_rd;
  logic [REG_ADDR_W-1:0]      reg_addr;
  logic [REG_DATA_W-1:0]      reg_wdata;
  logic                       sample_valid;
  logic [NUM_CH*SAMPLE_W-1:0] adc_data;
  logic                       rd_en;
  logic [REG_DATA_W-1:0]      reg_rdata;
  logic [WORD_W-1:0]          rd_data;
  logic                       fifo_empty;

  integer           seed;
  int               cycle_cnt = 0;
  // Expected DUT state, kept in step with commands and rows
  int               row_idx;
  int               fifo_count;
  logic             model_ovf;
  run_state_t       model_state;
  logic [ROW_W-1:0] shadow_rs;
  logic [ROW_W-1:0] shadow_re;
  logic [COL_W-1:0] shadow_cs;
  logic [COL_W-1:0] shadow_ce;
  logic [ROW_W-1:0] win_rs;
  logic [ROW_W-1:0] win_re;
  logic [COL_W-1:0] win_cs;
  logic [COL_W-1:0] win_ce;

  cps_daq_top #(
    .NUM_ROWS   (NUM_ROWS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cps_daq_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .sample_valid (sample_valid),
    .adc_data     (adc_data),
    .rd_en        (rd_en),
    .reg_rdata    (reg_rdata),
    .rd_data      (rd_data),
    .fifo_empty   (fifo_empty)
  );

  cps_checker checker_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_rd     (reg_rd),
    .reg_rdata  (reg_rdata),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .fifo_empty (fifo_empty)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // Row, column, six zero bits, sample
  function automatic logic [WORD_W-1:0] expected_word(input logic [ROW_W-1:0] row,
                                                      input logic [COL_W-1:0] col,
                                                      input logic [SAMPLE_W-1:0] sample);
    expected_word = {row, col, 6'b000000, sample};
  endfunction

  function automatic logic [REG_DATA_W-1:0] status_value();
    status_value = {4'b0000, model_state, (fifo_count == 0), model_ovf};
  endfunction

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr,
                           input logic [REG_DATA_W-1:0] data);
    @(posedge clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_wr <= 1'b0;
    case (addr)
      ADDR_ROW_START: shadow_rs = data[ROW_W-1:0];
      ADDR_ROW_END:   shadow_re = data[ROW_W-1:0];
      ADDR_COL_START: shadow_cs = data[COL_W-1:0];
      ADDR_COL_END:   shadow_ce = data[COL_W-1:0];
      default: ;
    endcase
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr,
                          input logic [REG_DATA_W-1:0] expected);
    checker_inst.queue_reg(expected);
    @(posedge clk);
    reg_rd   <= 1'b1;
    reg_addr <= addr;
    @(posedge clk);
    reg_rd <= 1'b0;
    @(posedge clk);
    @(posedge clk);
  endtask

  task automatic send_cmd(input logic [REG_DATA_W-1:0] bits);
    write_reg(ADDR_CMD, bits);
    if (bits[CMD_SET_BIT]) begin
      win_rs = shadow_rs;
      win_re = shadow_re;
      win_cs = shadow_cs;
      win_ce = shadow_ce;
    end
    if (bits[CMD_START_BIT] && model_state == IDLE) begin
      model_state = ARMED;
    end
    if (bits[CMD_STOP_BIT]) begin
      if (model_state == ARMED) begin
        model_state = IDLE;
      end else if (model_state == CAPTURE) begin
        model_state = DRAIN;
      end
    end
    if (bits[CMD_RESET_BIT]) begin
      model_state = IDLE;
      model_ovf   = 1'b0;
      fifo_count  = 0;
      row_idx     = 0;
      checker_inst.drop_words();
    end
    repeat (3) @(posedge clk);
  endtask

  // Words past a full FIFO are lost
  task automatic store_word(input logic [WORD_W-1:0] word);
    if (fifo_count < FIFO_DEPTH) begin
      checker_inst.queue_word(word);
      fifo_count++;
    end else begin
      model_ovf = 1'b1;
    end
  endtask

  task automatic send_row();
    logic [SAMPLE_W-1:0]        samples [NUM_CH];
    logic [NUM_CH*SAMPLE_W-1:0] flat;
    int                         words_before;
    for (int c = 0; c < NUM_CH; c++) begin
      samples[c] = SAMPLE_W'($random(seed));
      flat[c*SAMPLE_W +: SAMPLE_W] = samples[c];
    end
    @(posedge clk);
    sample_valid <= 1'b1;
    adc_data     <= flat;
    @(posedge clk);
    sample_valid <= 1'b0;
    words_before = fifo_count;
    if (row_idx == 0 && model_state == ARMED) begin
      model_state = CAPTURE;
    end
    if ((model_state == CAPTURE || model_state == DRAIN) && row_idx >= int'(win_rs) &&
        row_idx <= int'(win_re) && win_cs <= win_ce) begin
      for (int c = int'(win_cs); c <= int'(win_ce); c++) begin
        store_word(expected_word(ROW_W'(row_idx), COL_W'(c), samples[c]));
      end
      if (model_state == DRAIN && row_idx == int'(win_re)) begin
        model_state = IDLE;  // Frame closed after stop
      end
    end
    row_idx = (row_idx + 1) % NUM_ROWS;
    // First word in an empty FIFO is visible two cycles after the strobe
    @(negedge clk);
    if (words_before == 0 && fifo_count > 0) begin
      checker_inst.check_empty(1'b1);
    end
    @(negedge clk);
    if (words_before == 0 && fifo_count > 0) begin
      checker_inst.check_empty(1'b0);
    end
    repeat (STROBE_GAP - 3) @(posedge clk);
  endtask

  task automatic send_rows(input int count);
    repeat (count) send_row();
  endtask

  task automatic drain_fifo(input int max_words);
    int n;
    n = 0;
    @(posedge clk);
    while (!fifo_empty && n < max_words) begin
      rd_en <= 1'b1;
      @(posedge clk);
      rd_en <= 1'b0;
      @(posedge clk);
      n++;
    end
    fifo_count = fifo_count - n;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    sample_valid = 1'b0;
    adc_data     = '0;
    rd_en        = 1'b0;
    seed         = 74;
    row_idx      = 0;
    fifo_count   = 0;
    model_ovf    = 1'b0;
    model_state  = IDLE;
    shadow_rs    = '0;
    shadow_re    = '1;
    shadow_cs    = '0;
    shadow_ce    = '1;
    win_rs       = '0;
    win_re       = '1;
    win_cs       = '0;
    win_ce       = '1;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);

    // Shadow registers, command and status reads
    read_reg(ADDR_STATUS, status_value());
    write_reg(ADDR_ROW_START, 8'd1);
    write_reg(ADDR_ROW_END, 8'd3);
    write_reg(ADDR_COL_START, 8'd4);
    write_reg(ADDR_COL_END, 8'd8);
    read_reg(ADDR_ROW_START, 8'd1);
    read_reg(ADDR_ROW_END, 8'd3);
    read_reg(ADDR_COL_START, 8'd4);
    read_reg(ADDR_COL_END, 8'd8);
    read_reg(ADDR_CMD, 8'd0);
    checker_inst.end_test(1, "register readback");

    // Start lands mid-frame, capture waits for row 0
    send_cmd(8'h01 << CMD_SET_BIT);
    send_rows(3);
    send_cmd(8'h01 << CMD_START_BIT);
    send_rows(5);
    send_rows(NUM_ROWS);
    drain_fifo(1000);
    checker_inst.end_test(2, "window capture");

    write_reg(ADDR_ROW_START, 8'd4);
    write_reg(ADDR_ROW_END, 8'd6);
    write_reg(ADDR_COL_START, 8'd10);
    write_reg(ADDR_COL_END, 8'd13);
    send_rows(NUM_ROWS);
    drain_fifo(1000);
    send_cmd(8'h01 << CMD_SET_BIT);
    send_rows(NUM_ROWS);
    drain_fifo(1000);
    checker_inst.end_test(3, "shadow window switch");

    // Stop after row 4, frame runs on through row 6
    send_rows(5);
    send_cmd(8'h01 << CMD_STOP_BIT);
    send_rows(2);
    send_rows(1 + NUM_ROWS);
    drain_fifo(1000);
    read_reg(ADDR_STATUS, status_value());
    checker_inst.end_test(4, "stop mid-frame");

    write_reg(ADDR_ROW_START, 8'd0);
    write_reg(ADDR_ROW_END, 8'd1);
    write_reg(ADDR_COL_START, 8'd0);
    write_reg(ADDR_COL_END, 8'd15);
    send_cmd(8'h01 << CMD_SET_BIT);
    send_cmd(8'h01 << CMD_START_BIT);
    send_rows(1);
    send_cmd(8'h01 << CMD_STOP_BIT);
    send_rows(1);
    drain_fifo(FIFO_DEPTH - 1);
    read_reg(ADDR_STATUS, status_value());
    send_cmd(8'h01 << CMD_RESET_BIT);
    read_reg(ADDR_STATUS, status_value());
    drain_fifo(1000);
    checker_inst.end_test(5, "overflow and soft reset");

    checker_inst.print_summary();
    if (checker_inst.error_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verilog/cmd_regs.sv
module cmd_regs import cps_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  reg_wr,
  input  logic                  reg_rd,
  input  logic [REG_ADDR_W-1:0] reg_addr,
  input  logic [REG_DATA_W-1:0] reg_wdata,
  input  run_state_t            run_state,
  input  logic                  overflow,
  input  logic                  fifo_empty,
  output logic [REG_DATA_W-1:0] reg_rdata,
  output logic [ROW_W-1:0]      row_start,
  output logic [ROW_W-1:0]      row_end,
  output logic [COL_W-1:0]      col_start,
  output logic [COL_W-1:0]      col_end,
  output logic                  start_pulse,
  output logic                  stop_pulse,
  output logic                  soft_rst
);

  logic [ROW_W-1:0] shadow_row_start;
  logic [ROW_W-1:0] shadow_row_end;
  logic [COL_W-1:0] shadow_col_start;
  logic [COL_W-1:0] shadow_col_end;
  logic             set_pulse;
  logic             cmd_wr;

  assign cmd_wr = reg_wr && (reg_addr == ADDR_CMD);

  // Shadow copy, written directly by the host
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow_row_start <= '0;
      shadow_row_end   <= '1;
      shadow_col_start <= '0;
      shadow_col_end   <= '1;
    end else if (reg_wr) begin
      case (reg_addr)
        ADDR_ROW_START: shadow_row_start <= reg_wdata[ROW_W-1:0];
        ADDR_ROW_END:   shadow_row_end   <= reg_wdata[ROW_W-1:0];
        ADDR_COL_START: shadow_col_start <= reg_wdata[COL_W-1:0];
        ADDR_COL_END:   shadow_col_end   <= reg_wdata[COL_W-1:0];
        default: ;
      endcase
    end
  end

  // Command register holds no value, each set bit gives one pulse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_pulse <= 1'b0;
      stop_pulse  <= 1'b0;
      set_pulse   <= 1'b0;
      soft_rst    <= 1'b0;
    end else begin
      start_pulse <= cmd_wr && reg_wdata[CMD_START_BIT];
      stop_pulse  <= cmd_wr && reg_wdata[CMD_STOP_BIT];
      set_pulse   <= cmd_wr && reg_wdata[CMD_SET_BIT];
      soft_rst    <= cmd_wr && reg_wdata[CMD_RESET_BIT];
    end
  end

  // Active window, full frame until the first set
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      row_start <= '0;
      row_end   <= '1;
      col_start <= '0;
      col_end   <= '1;
    end else if (set_pulse) begin
      row_start <= shadow_row_start;
      row_end   <= shadow_row_end;
      col_start <= shadow_col_start;
      col_end   <= shadow_col_end;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (reg_addr)
        ADDR_ROW_START: reg_rdata <= REG_DATA_W'(shadow_row_start);
        ADDR_ROW_END:   reg_rdata <= REG_DATA_W'(shadow_row_end);
        ADDR_COL_START: reg_rdata <= REG_DATA_W'(shadow_col_start);
        ADDR_COL_END:   reg_rdata <= REG_DATA_W'(shadow_col_end);
        ADDR_STATUS:    reg_rdata <= REG_DATA_W'({run_state, fifo_empty, overflow});
        default:        reg_rdata <= '0; // Command reg reads zero
      endcase
    end
  end

endmodule

// File: verilog/cps_daq_top.sv
module cps_daq_top import cps_pkg::*; #(
  parameter int NUM_ROWS   = 64,
  parameter int FIFO_DEPTH = 256
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       reg_wr,
  input  logic                       reg_rd,
  input  logic [REG_ADDR_W-1:0]      reg_addr,
  input  logic [REG_DATA_W-1:0]      reg_wdata,
  input  logic                       sample_valid,
  input  logic [NUM_CH*SAMPLE_W-1:0] adc_data,
  input  logic                       rd_en,
  output logic [REG_DATA_W-1:0]      reg_rdata,
  output logic [WORD_W-1:0]          rd_data,
  output logic                       fifo_empty
);

  // Active readout window
  logic [ROW_W-1:0]  row_start;
  logic [ROW_W-1:0]  row_end;
  logic [COL_W-1:0]  col_start;
  logic [COL_W-1:0]  col_end;

  logic              start_pulse;
  logic              stop_pulse;
  logic              soft_rst;
  logic              word_valid;
  logic [WORD_W-1:0] word_data;
  logic              frame_start;
  logic              frame_end;
  logic              fifo_wr;
  logic              fifo_full;
  logic              overflow;
  run_state_t        run_state;

  cmd_regs cmd_regs_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .reg_wr      (reg_wr),
    .reg_rd      (reg_rd),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .run_state   (run_state),
    .overflow    (overflow),
    .fifo_empty  (fifo_empty),
    .reg_rdata   (reg_rdata),
    .row_start   (row_start),
    .row_end     (row_end),
    .col_start   (col_start),
    .col_end     (col_end),
    .start_pulse (start_pulse),
    .stop_pulse  (stop_pulse),
    .soft_rst    (soft_rst)
  );

  frame_packer #(
    .NUM_ROWS (NUM_ROWS)
  ) frame_packer_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .soft_rst     (soft_rst),
    .sample_valid (sample_valid),
    .adc_data     (adc_data),
    .row_start    (row_start),
    .row_end      (row_end),
    .col_start    (col_start),
    .col_end      (col_end),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .frame_start  (frame_start),
    .frame_end    (frame_end)
  );

  run_control run_control_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .soft_rst    (soft_rst),
    .start_pulse (start_pulse),
    .stop_pulse  (stop_pulse),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .word_valid  (word_valid),
    .fifo_full   (fifo_full),
    .fifo_wr     (fifo_wr),
    .run_state   (run_state),
    .overflow    (overflow)
  );

  word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) word_fifo_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .soft_rst (soft_rst),
    .wr_en    (fifo_wr),
    .wr_data  (word_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (fifo_full),
    .empty    (fifo_empty)
  );

endmodule

// File: verilog/cps_pkg.sv
package cps_pkg;

  // ADC row and packed word geometry
  localparam int NUM_CH     = 16;
  localparam int SAMPLE_W   = 16;
  localparam int WORD_W     = 32;
  localparam int ROW_W      = 6;
  localparam int COL_W      = 4;

  // Host register port
  localparam int REG_ADDR_W = 5;
  localparam int REG_DATA_W = 8;

  localparam logic [REG_ADDR_W-1:0] ADDR_CMD       = 5'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_ROW_START = 5'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_ROW_END   = 5'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_COL_START = 5'd3;
  localparam logic [REG_ADDR_W-1:0] ADDR_COL_END   = 5'd4;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS    = 5'd5;

  // Bits of a command register write, one pulse per set bit
  localparam int CMD_START_BIT = 0;
  localparam int CMD_STOP_BIT  = 1;
  localparam int CMD_SET_BIT   = 2;
  localparam int CMD_RESET_BIT = 3;

  // Run state, also reported in the status register
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ARMED   = 2'd1,
    CAPTURE = 2'd2,
    DRAIN   = 2'd3
  } run_state_t;

endpackage

// File: verilog/frame_packer.sv
module frame_packer import cps_pkg::*; #(
  parameter int NUM_ROWS = 64
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       soft_rst,
  input  logic                       sample_valid,
  input  logic [NUM_CH*SAMPLE_W-1:0] adc_data,
  input  logic [ROW_W-1:0]           row_start,
  input  logic [ROW_W-1:0]           row_end,
  input  logic [COL_W-1:0]           col_start,
  input  logic [COL_W-1:0]           col_end,
  output logic                       word_valid,
  output logic [WORD_W-1:0]          word_data,
  output logic                       frame_start,
  output logic                       frame_end
);

  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(NUM_ROWS - 1);
  localparam int               PAD_W    = WORD_W - ROW_W - COL_W - SAMPLE_W;

  logic [ROW_W-1:0]           row_cnt;    // Row of the next strobe
  logic [ROW_W-1:0]           row_q;
  logic [NUM_CH*SAMPLE_W-1:0] row_buf;
  logic                       scanning;
  logic [COL_W-1:0]           col;
  logic [COL_W-1:0]           col_end_q;
  logic                       last_row_q;
  logic [ROW_W-1:0]           final_row;
  logic                       in_window;
  logic [SAMPLE_W-1:0]        sample;

  // A row_end past the frame is clamped to the last real row
  assign final_row = (row_end > LAST_ROW) ? LAST_ROW : row_end;
  assign in_window = (row_cnt >= row_start) && (row_cnt <= row_end) &&
                     (col_start <= col_end);

  assign frame_start = sample_valid && (row_cnt == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      row_cnt <= '0;
    end else if (soft_rst) begin
      row_cnt <= '0;
    end else if (sample_valid) begin
      if (row_cnt == LAST_ROW) begin
        row_cnt <= '0;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      row_buf <= adc_data;
      row_q   <= row_cnt;
    end
  end

  // Column scan, window end captured with the row
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scanning   <= 1'b0;
      col        <= '0;
      col_end_q  <= '0;
      last_row_q <= 1'b0;
    end else if (soft_rst) begin
      scanning <= 1'b0;
    end else if (sample_valid) begin
      scanning   <= in_window;
      col        <= col_start;
      col_end_q  <= col_end;
      last_row_q <= (row_cnt == final_row);
    end else if (scanning) begin
      if (col == col_end_q) begin
        scanning <= 1'b0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign sample     = row_buf[col*SAMPLE_W +: SAMPLE_W];
  assign word_valid = scanning;
  assign word_data  = {row_q, col, {PAD_W{1'b0}}, sample};
  assign frame_end  = scanning && last_row_q && (col == col_end_q);

endmodule

// File: verilog/run_control.sv
module run_control import cps_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       soft_rst,
  input  logic       start_pulse,
  input  logic       stop_pulse,
  input  logic       frame_start,
  input  logic       frame_end,
  input  logic       word_valid,
  input  logic       fifo_full,
  output logic       fifo_wr,
  output run_state_t run_state,
  output logic       overflow
);

  run_state_t state_next;
  logic       capturing;

  // Words pass only between a frame start and the frame end after stop
  assign capturing = (run_state == CAPTURE) || (run_state == DRAIN);
  assign fifo_wr   = word_valid && capturing && !fifo_full;

  always_comb begin
    state_next = run_state;
    case (run_state)
      IDLE: begin
        if (start_pulse) begin
          state_next = ARMED;
        end
      end
      ARMED: begin
        if (stop_pulse) begin
          state_next = IDLE;
        end else if (frame_start) begin
          state_next = CAPTURE;
        end
      end
      CAPTURE: begin
        // Stop on the last word closes this frame at once
        if (stop_pulse && frame_end) begin
          state_next = IDLE;
        end else if (stop_pulse) begin
          state_next = DRAIN;
        end
      end
      DRAIN: begin
        if (frame_end) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_state <= IDLE;
    end else if (soft_rst) begin
      run_state <= IDLE;
    end else begin
      run_state <= state_next;
    end
  end

  // Sticky until soft reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      overflow <= 1'b0;
    end else if (soft_rst) begin
      overflow <= 1'b0;
    end else if (word_valid && capturing && fifo_full) begin
      overflow <= 1'b1; // Word dropped
    end
  end

endmodule

// File: verilog/word_fifo.sv
module word_fifo import cps_pkg::*; #(
  parameter int FIFO_DEPTH = 256 // Power of two
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              soft_rst,
  input  logic              wr_en,
  input  logic [WORD_W-1:0] wr_data,
  input  logic              rd_en,
  output logic [WORD_W-1:0] rd_data,
  output logic              full,
  output logic              empty
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [AW:0]       wr_ptr;  // Extra bit tells full from empty
  logic [AW:0]       rd_ptr;
  logic              do_wr;
  logic              do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (soft_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
    if (do_rd) begin
      rd_data <= mem[rd_ptr[AW-1:0]];
    end
  end

endmodule
